// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = rv_core_tb
FILELIST = rv_core.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# The log decides pass or fail, not the simulator's exit status
run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== rv_core.f ====
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/fetch_unit.sv
verilog/instr_decoder.sv
verilog/exec_unit.sv
verilog/register_file.sv
verilog/rv_core_top.sv
verification/rv_core_tb.sv

// ==== verification/rv_core_tb.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_core_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_TESTS    = 6;
  localparam int T_RESET      = 0;
  localparam int T_SP         = 1;
  localparam int T_ARITH      = 2;
  localparam int T_X0         = 3;
  localparam int T_FLOW       = 4;
  localparam int T_LATENCY    = 5;
  localparam logic [`XLEN-1:0] ENTRY     = 64'h0000_0000_8000_0000;
  localparam logic [`XLEN-1:0] STACK_TOP = 64'h0000_0000_8003_fff0;

  logic                   clk;
  logic                   reset;
  logic [`XLEN-1:0]       entry;
  logic [`XLEN-1:0]       stackptr;
  logic                   instr_valid;
  logic [`INSTR_W-1:0]    instr;
  logic                   fetch_req;
  logic [`XLEN-1:0]       fetch_addr;
  logic                   wb_valid;
  logic [`REG_ADDR_W-1:0] wb_rd;
  logic [`XLEN-1:0]       wb_data;

  // Program ROM and the shadow model
  logic [`INSTR_W-1:0]    rom_words [$];
  int                     rom_tags [$];
  logic [`XLEN-1:0]       shadow_regs [`REG_COUNT];
  logic [`XLEN-1:0]       shadow_pc;
  logic [`REG_ADDR_W-1:0] exp_rd;
  logic [`XLEN-1:0]       exp_data;
  logic                   boot_pending;
  logic                   req_seen;
  logic [`XLEN-1:0]       addr_seen;
  int                     cur_tag;
  int                     errors [NUM_TESTS];
  bit                     reported [NUM_TESTS];
  int                     passed;
  int                     failed;
  integer                 seed;

  rv_core_top i_rv_core_top (
    .clk         (clk),
    .reset       (reset),
    .entry       (entry),
    .stackptr    (stackptr),
    .instr_valid (instr_valid),
    .instr       (instr),
    .fetch_req   (fetch_req),
    .fetch_addr  (fetch_addr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Request and address as the DUT sees them on the rising edge
  always @(posedge clk) begin
    req_seen  <= fetch_req;
    addr_seen <= fetch_addr;
  end

  function automatic string test_name(input int id);
    case (id)
      T_RESET:   return "reset and start";
      T_SP:      return "stack pointer";
      T_ARITH:   return "arithmetic";
      T_X0:      return "x0 rule";
      T_FLOW:    return "control flow";
      T_LATENCY: return "latency";
      default:   return "unknown";
    endcase
  endfunction

  task automatic report_mismatch(input int id, input string sig,
                                 input logic [`XLEN-1:0] got,
                                 input logic [`XLEN-1:0] expected);
    errors[id]++;
    $display("FAIL %s: got %h, expected %h at %0t", sig, got, expected, $time);
  endtask

  task automatic report_problem(input int id, input string msg);
    errors[id]++;
    $display("Error: %s at %0t", msg, $time);
  endtask

  task automatic finish_test(input int id);
    if (id >= 0 && !reported[id]) begin
      reported[id] = 1'b1;
      if (errors[id] == 0) begin
        passed++;
        $display("test %s: PASS", test_name(id));
      end else begin
        failed++;
        $display("test %s: FAIL, %0d errors", test_name(id), errors[id]);
      end
    end
  endtask

  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, `OPC_LUI};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
  endfunction

  task automatic emit(input logic [31:0] w, input int tag);
    rom_words.push_back(w);
    rom_tags.push_back(tag);
  endtask

  task automatic load_program();
    emit(enc_i(12'd0, 5'd2, `F3_ADD, 5'd5), T_SP);
    emit(enc_lui(20'h12345, 5'd6), T_ARITH);
    emit(enc_i(12'hffb, 5'd0, `F3_ADD, 5'd7), T_ARITH);
    emit(enc_i(12'h678, 5'd6, `F3_ADD, 5'd6), T_ARITH);
    emit(enc_r(7'd0, 5'd7, 5'd6, `F3_ADD, 5'd8), T_ARITH);
    emit(enc_r(`F7_SUB, 5'd7, 5'd6, `F3_ADD, 5'd9), T_ARITH);
    emit(enc_r(7'd0, 5'd7, 5'd6, `F3_AND, 5'd10), T_ARITH);
    emit(enc_r(7'd0, 5'd7, 5'd6, `F3_OR, 5'd11), T_ARITH);
    emit(enc_r(7'd0, 5'd7, 5'd6, `F3_XOR, 5'd12), T_ARITH);
    emit(enc_r(7'd0, 5'd6, 5'd7, `F3_SLT, 5'd13), T_ARITH);
    emit(enc_r(7'd0, 5'd7, 5'd6, `F3_SLT, 5'd14), T_ARITH);
    emit(enc_i(12'd36, 5'd0, `F3_ADD, 5'd15), T_ARITH);
    emit(enc_r(7'd0, 5'd15, 5'd6, `F3_SLL, 5'd16), T_ARITH);
    emit(enc_r(7'd0, 5'd15, 5'd7, `F3_SRL, 5'd17), T_ARITH);
    emit(enc_i(12'h0f0, 5'd7, `F3_AND, 5'd18), T_ARITH);
    emit(enc_i(12'hf00, 5'd6, `F3_OR, 5'd19), T_ARITH);
    emit(enc_i(12'h7ff, 5'd6, `F3_XOR, 5'd20), T_ARITH);
    emit(enc_lui(20'h80000, 5'd21), T_ARITH);
    emit(enc_i(12'd123, 5'd6, `F3_ADD, 5'd0), T_X0);
    emit(enc_r(7'd0, 5'd6, 5'd0, `F3_OR, 5'd22), T_X0);
    emit(enc_r(7'd0, 5'd0, 5'd0, `F3_ADD, 5'd23), T_X0);
    emit(enc_i(12'd7, 5'd0, `F3_ADD, 5'd24), T_FLOW);
    emit(enc_i(12'd7, 5'd0, `F3_ADD, 5'd25), T_FLOW);
    // Taken BEQ skips the next word
    emit(enc_b(13'd8, 5'd25, 5'd24, `F3_BEQ), T_FLOW);
    emit(enc_i(12'd1, 5'd0, `F3_ADD, 5'd26), T_FLOW);
    emit(enc_b(13'd8, 5'd25, 5'd24, `F3_BNE), T_FLOW);
    emit(enc_b(13'd8, 5'd0, 5'd24, `F3_BNE), T_FLOW);
    emit(enc_i(12'd2, 5'd0, `F3_ADD, 5'd26), T_FLOW);
    emit(enc_b(13'd8, 5'd0, 5'd24, `F3_BEQ), T_FLOW);
    emit(enc_jal(21'd8, 5'd1), T_FLOW);
    emit(enc_i(12'd3, 5'd0, `F3_ADD, 5'd26), T_FLOW);
    // Undecoded custom-0 opcode with x27 in its rd field
    emit(32'h0000_0d8b, T_FLOW);
    emit(enc_r(7'd0, 5'd1, 5'd24, `F3_ADD, 5'd28), T_FLOW);
  endtask

  // Reference model update for each word the ROM hands out
  task automatic predict(input logic [`INSTR_W-1:0] w, input logic [`XLEN-1:0] pc);
    logic [6:0]             opc;
    logic [2:0]             f3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       a;
    logic [`XLEN-1:0]       b;
    logic [`XLEN-1:0]       imm;
    logic [`XLEN-1:0]       val;
    opc       = w[6:0];
    f3        = w[14:12];
    rd        = w[11:7];
    a         = shadow_regs[w[19:15]];
    b         = shadow_regs[w[24:20]];
    val       = '0;
    exp_rd    = '0;
    shadow_pc = pc + `PC_STEP;
    case (opc)
      `OPC_OP: begin
        exp_rd = rd;
        case (f3)
          `F3_ADD: val = (w[31:25] == `F7_SUB) ? a - b : a + b;
          `F3_SLL: val = a << b[5:0];
          `F3_SLT: val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          `F3_XOR: val = a ^ b;
          `F3_SRL: val = a >> b[5:0];
          `F3_OR:  val = a | b;
          `F3_AND: val = a & b;
          default: exp_rd = '0;
        endcase
      end
      `OPC_OP_IMM: begin
        imm    = {{52{w[31]}}, w[31:20]};
        exp_rd = rd;
        case (f3)
          `F3_ADD: val = a + imm;
          `F3_XOR: val = a ^ imm;
          `F3_OR:  val = a | imm;
          `F3_AND: val = a & imm;
          default: exp_rd = '0;
        endcase
      end
      `OPC_LUI: begin
        exp_rd = rd;
        val    = {{32{w[31]}}, w[31:12], 12'h000};
      end
      `OPC_BRANCH: begin
        imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        if ((f3 == `F3_BEQ && a == b) || (f3 == `F3_BNE && a != b)) begin
          shadow_pc = pc + imm;
        end
      end
      `OPC_JAL: begin
        imm       = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        exp_rd    = rd;
        val       = pc + `PC_STEP;
        shadow_pc = pc + imm;
      end
      default: begin
        exp_rd = '0;
      end
    endcase
    exp_data = val;
    if (exp_rd != '0) begin
      shadow_regs[exp_rd] = val;
    end
  endtask

  a_reset_quiet: assert property (@(posedge clk) reset && $past(reset) |-> !wb_valid)
    else report_mismatch(T_RESET, "wb_valid", {63'b0, $sampled(wb_valid)}, 64'd0);

  a_boot_fetch: assert property (@(posedge clk) disable iff (reset)
    fetch_req && boot_pending |-> fetch_addr == entry)
    else report_mismatch(T_RESET, "fetch_addr", $sampled(fetch_addr), entry);

  a_retire_rd: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> wb_rd == exp_rd)
    else report_mismatch(cur_tag, "wb_rd", {59'b0, $sampled(wb_rd)}, {59'b0, exp_rd});

  // Data is only defined when a register is written
  a_retire_data: assert property (@(posedge clk) disable iff (reset)
    wb_valid && exp_rd != '0 |-> wb_data == exp_data)
    else report_mismatch(cur_tag, "wb_data", $sampled(wb_data), exp_data);

  a_next_fetch: assert property (@(posedge clk) disable iff (reset)
    fetch_req && !boot_pending |-> fetch_addr == shadow_pc)
    else report_mismatch(cur_tag, "fetch_addr", $sampled(fetch_addr), shadow_pc);

  a_retire_latency: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> $past(instr_valid, 3))
    else report_problem(T_LATENCY, "wb_valid without instr_valid 3 cycles earlier");

  a_retire_missing: assert property (@(posedge clk) disable iff (reset)
    $past(instr_valid, 3) |-> wb_valid)
    else report_problem(T_LATENCY, "no wb_valid 3 cycles after instr_valid");

  a_fetch_with_retire: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> fetch_req)
    else report_problem(T_LATENCY, "fetch_req not raised together with wb_valid");

  a_fetch_after_retire: assert property (@(posedge clk) disable iff (reset)
    fetch_req && !boot_pending |-> wb_valid)
    else report_problem(T_LATENCY, "fetch_req raised without a retirement");

  initial begin : stimulus
    logic [`XLEN-1:0] addr;
    logic [`XLEN-1:0] offset;
    int               idx;
    int               next_tag;
    int               prev_tag;
    int               delay;
    int               total;
    int               i;
    bit               done;
    reset        = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    entry        = ENTRY;
    stackptr     = STACK_TOP;
    boot_pending = 1'b1;
    seed         = 32'ha74a;
    cur_tag      = T_RESET;
    exp_rd       = '0;
    exp_data     = '0;
    shadow_pc    = ENTRY;
    passed       = 0;
    failed       = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      errors[i]   = 0;
      reported[i] = 1'b0;
    end
    for (i = 0; i < `REG_COUNT; i++) begin
      shadow_regs[i] = '0;
    end
    shadow_regs[`SP_REG] = STACK_TOP;
    load_program();

    repeat (RESET_CYCLES) @(negedge clk);
    reset    = 1'b0;
    prev_tag = T_RESET;
    done     = 1'b0;

    // ROM responder serves one request at a time
    while (!done) begin
      @(negedge clk);
      instr_valid = 1'b0;
      if (req_seen) begin
        boot_pending = 1'b0;
        addr         = addr_seen;
        offset       = addr - ENTRY;
        idx          = int'(offset >> 2);
        if ((offset >> 2) >= rom_words.size()) begin
          next_tag = -1;
        end else begin
          next_tag = rom_tags[idx];
        end
        if (next_tag != prev_tag) begin
          finish_test(prev_tag);
        end
        if (next_tag < 0) begin
          done = 1'b1;
        end else begin
          delay = 1 + ({$random(seed)} % 4);
          repeat (delay - 1) @(negedge clk);
          predict(rom_words[idx], addr);
          cur_tag     = next_tag;
          prev_tag    = next_tag;
          instr       = rom_words[idx];
          instr_valid = 1'b1;
        end
      end
    end

    finish_test(T_LATENCY);
    for (i = 0; i < NUM_TESTS; i++) begin
      if (!reported[i]) begin
        failed++;
        $display("test %s: FAIL, never reached", test_name(i));
      end
    end
    total = 0;
    for (i = 0; i < NUM_TESTS; i++) begin
      total += errors[i];
    end
    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, passed, failed, total);
    if (failed == 0 && total == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // At most 7 cycles per instruction with the longest ROM delay
  initial begin : watchdog
    int limit;
    @(negedge clk);
    limit = RESET_CYCLES + 10 * rom_words.size();
    repeat (limit) @(posedge clk);
    $display("Timeout: program did not finish within %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module exec_unit
  import rv_core_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             dec_valid,
  input  dec_t             dec,
  input  logic [`XLEN-1:0] rs1_data,
  input  logic [`XLEN-1:0] rs2_data,
  output logic             ex_valid,
  output ex_result_t       ex_result
);

  logic [`XLEN-1:0] op_b;
  logic [5:0]       shamt;
  logic [`XLEN-1:0] alu_out;
  logic [`XLEN-1:0] pc_seq;
  logic [`XLEN-1:0] pc_target;
  logic             taken;
  ex_result_t       result_next;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[5:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_out = rs1_data + op_b;
      ALU_SUB:  alu_out = rs1_data - op_b;
      ALU_AND:  alu_out = rs1_data & op_b;
      ALU_OR:   alu_out = rs1_data | op_b;
      ALU_XOR:  alu_out = rs1_data ^ op_b;
      ALU_SLT:  alu_out = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
      ALU_SLL:  alu_out = rs1_data << shamt;
      ALU_SRL:  alu_out = rs1_data >> shamt;
      ALU_PASS: alu_out = op_b;
      default:  alu_out = '0;
    endcase
  end

  assign pc_seq    = dec.pc + `PC_STEP;
  assign pc_target = dec.pc + dec.imm;

  // BNE inverts the equality compare
  assign taken = dec.is_branch && ((rs1_data == rs2_data) ^ dec.branch_ne);

  always_comb begin
    result_next.rd      = dec.rd;
    result_next.data    = dec.is_jal ? pc_seq : alu_out;
    result_next.next_pc = (dec.is_jal || taken) ? pc_target : pc_seq;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      ex_result <= result_next;
    end
  end

  // Only one instruction in flight, so never back to back
  a_ex_single_pulse: assert property (
    @(posedge clk) disable iff (reset) ex_valid |=> !ex_valid
  ) else $error("ex_valid held for more than one cycle");

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module fetch_unit
  import rv_core_pkg::*;
(
  input  logic                clk,
  input  logic                reset,
  input  logic [`XLEN-1:0]    entry,
  input  logic                instr_valid,
  input  logic [`INSTR_W-1:0] instr,
  input  logic                ex_valid,
  input  ex_result_t          ex_result,
  output logic                fetch_req,
  output logic [`XLEN-1:0]    fetch_addr,
  output logic                fetched_valid,
  output instr_u              fetched_instr,
  output logic [`XLEN-1:0]    fetched_pc
);

  logic [`XLEN-1:0] pc_q;
  logic             req_q;
  logic             waiting_q;
  logic             reset_q;
  logic             boot_req;

  // Reset release detector, gives the very first request
  always_ff @(posedge clk) begin
    reset_q <= reset;
  end

  assign boot_req = reset_q & ~reset;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q      <= entry;
      req_q     <= 1'b0;
      waiting_q <= 1'b0;
    end else begin
      // Redirect after every executed instruction
      req_q <= ex_valid;
      if (ex_valid) begin
        pc_q <= ex_result.next_pc;
      end
      if (instr_valid) begin
        waiting_q <= 1'b0;
      end else if (fetch_req) begin
        waiting_q <= 1'b1;
      end
    end
  end

  assign fetch_req  = req_q | boot_req;
  assign fetch_addr = pc_q;

  // Word goes straight to the decoder with the PC that fetched it
  assign fetched_valid = instr_valid;
  assign fetched_instr = instr;
  assign fetched_pc    = pc_q;

  a_no_unrequested_instr: assert property (
    @(posedge clk) disable iff (reset) instr_valid |-> waiting_q
  ) else $error("instr_valid without an outstanding fetch_req");

endmodule

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module instr_decoder
  import rv_core_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             fetched_valid,
  input  instr_u           fetched_instr,
  input  logic [`XLEN-1:0] fetched_pc,
  output logic             dec_valid,
  output dec_t             dec
);

  dec_t             dec_next;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;

  assign opcode = fetched_instr.r.opcode;
  assign funct3 = fetched_instr.r.funct3;

  // Immediates, each read through its own format view
  assign imm_i = {{(`XLEN-12){fetched_instr.i.imm[11]}}, fetched_instr.i.imm};
  assign imm_u = {{(`XLEN-32){fetched_instr.u.imm[19]}}, fetched_instr.u.imm, 12'b0};
  assign imm_b = {{(`XLEN-13){fetched_instr.b.imm_12}}, fetched_instr.b.imm_12,
                  fetched_instr.b.imm_11, fetched_instr.b.imm_10_5,
                  fetched_instr.b.imm_4_1, 1'b0};
  assign imm_j = {{(`XLEN-21){fetched_instr.j.imm_20}}, fetched_instr.j.imm_20,
                  fetched_instr.j.imm_19_12, fetched_instr.j.imm_11,
                  fetched_instr.j.imm_10_1, 1'b0};

  always_comb begin
    dec_next     = '0;
    dec_next.pc  = fetched_pc;
    dec_next.rs1 = fetched_instr.r.rs1;
    dec_next.rs2 = fetched_instr.r.rs2;
    dec_next.rd  = fetched_instr.r.rd;

    case (opcode)
      `OPC_OP: begin
        dec_next.writes_rd = 1'b1;
        case (funct3)
          `F3_ADD: begin
            if (fetched_instr.r.funct7 == `F7_SUB) begin
              dec_next.alu_op = ALU_SUB;
            end else begin
              dec_next.alu_op = ALU_ADD;
            end
          end
          `F3_SLL: dec_next.alu_op = ALU_SLL;
          `F3_SLT: dec_next.alu_op = ALU_SLT;
          `F3_XOR: dec_next.alu_op = ALU_XOR;
          `F3_SRL: dec_next.alu_op = ALU_SRL;
          `F3_OR:  dec_next.alu_op = ALU_OR;
          `F3_AND: dec_next.alu_op = ALU_AND;
          // SLTU is not supported
          default: dec_next.writes_rd = 1'b0;
        endcase
      end

      `OPC_OP_IMM: begin
        dec_next.imm       = imm_i;
        dec_next.use_imm   = 1'b1;
        dec_next.writes_rd = 1'b1;
        case (funct3)
          `F3_ADD: dec_next.alu_op = ALU_ADD;
          `F3_XOR: dec_next.alu_op = ALU_XOR;
          `F3_OR:  dec_next.alu_op = ALU_OR;
          `F3_AND: dec_next.alu_op = ALU_AND;
          default: dec_next.writes_rd = 1'b0;
        endcase
      end

      `OPC_LUI: begin
        dec_next.imm       = imm_u;
        dec_next.use_imm   = 1'b1;
        dec_next.alu_op    = ALU_PASS;
        dec_next.writes_rd = 1'b1;
      end

      `OPC_BRANCH: begin
        dec_next.imm       = imm_b;
        dec_next.is_branch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
        dec_next.branch_ne = (funct3 == `F3_BNE);
      end

      `OPC_JAL: begin
        dec_next.imm       = imm_j;
        dec_next.is_jal    = 1'b1;
        dec_next.writes_rd = 1'b1;
      end

      // Anything else falls through as a no-op
      default: begin
        dec_next.writes_rd = 1'b0;
      end
    endcase

    if (!dec_next.writes_rd) begin
      dec_next.rd = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fetched_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fetched_valid) begin
      dec <= dec_next;
    end
  end

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module register_file
  import rv_core_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`XLEN-1:0]      stackptr,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  logic                  ex_valid,
  input  ex_result_t            ex_result,
  output logic [`XLEN-1:0]      rs1_data,
  output logic [`XLEN-1:0]      rs2_data,
  output logic                  wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]      wb_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // Clear everything, stack pointer starts at stackptr
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= (i == `SP_REG) ? stackptr : '0;
      end
    end else if (ex_valid && ex_result.rd != '0) begin
      regs[ex_result.rd] <= ex_result.data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // Retire report, one cycle behind the write
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      wb_rd   <= ex_result.rd;
      wb_data <= ex_result.data;
    end
  end

  a_x0_zero: assert property (
    @(posedge clk) disable iff (reset) regs[0] == '0
  ) else $error("x0 holds a nonzero value");

endmodule

// ==== verilog/rv_core_macros.svh ====
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Datapath and register file sizes
`define XLEN        64
`define INSTR_W     32
`define REG_COUNT   32
`define REG_ADDR_W  5

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// funct3 codes, ALU group and branch group overlap
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_BEQ      3'b000
`define F3_BNE      3'b001

`define F7_SUB      7'b0100000

`define PC_STEP     64'd4
`define SP_REG      5'd2

`endif

// ==== verilog/rv_core_pkg.sv ====
`include "rv_core_macros.svh"

package rv_core_pkg;

  // Instruction formats, all 32 bits, MSB first
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]            imm;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0]            imm;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  // Branch offset is scattered over the word
  typedef struct packed {
    logic                   imm_12;
    logic [5:0]             imm_10_5;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [3:0]             imm_4_1;
    logic                   imm_11;
    logic [6:0]             opcode;
  } b_fmt_t;

  typedef struct packed {
    logic                   imm_20;
    logic [9:0]             imm_10_1;
    logic                   imm_11;
    logic [7:0]             imm_19_12;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS
  } alu_op_e;

  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   is_branch;
    logic                   branch_ne;
    logic                   is_jal;
    logic                   writes_rd;
  } dec_t;

  // rd of zero means nothing gets written
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
    logic [`XLEN-1:0]       next_pc;
  } ex_result_t;

endpackage

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/10ps
`include "rv_core_macros.svh"

module rv_core_top
  import rv_core_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`XLEN-1:0]       entry,
  input  logic [`XLEN-1:0]       stackptr,
  input  logic                   instr_valid,
  input  logic [`INSTR_W-1:0]    instr,
  output logic                   fetch_req,
  output logic [`XLEN-1:0]       fetch_addr,
  output logic                   wb_valid,
  output logic [`REG_ADDR_W-1:0] wb_rd,
  output logic [`XLEN-1:0]       wb_data
);

  logic             fetched_valid;
  instr_u           fetched_instr;
  logic [`XLEN-1:0] fetched_pc;
  logic             dec_valid;
  dec_t             dec;
  logic [`XLEN-1:0] rs1_data;
  logic [`XLEN-1:0] rs2_data;
  logic             ex_valid;
  ex_result_t       ex_result;

  fetch_unit i_fetch_unit (
    .clk           (clk),
    .reset         (reset),
    .entry         (entry),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .ex_valid      (ex_valid),
    .ex_result     (ex_result),
    .fetch_req     (fetch_req),
    .fetch_addr    (fetch_addr),
    .fetched_valid (fetched_valid),
    .fetched_instr (fetched_instr),
    .fetched_pc    (fetched_pc)
  );

  instr_decoder i_instr_decoder (
    .clk           (clk),
    .reset         (reset),
    .fetched_valid (fetched_valid),
    .fetched_instr (fetched_instr),
    .fetched_pc    (fetched_pc),
    .dec_valid     (dec_valid),
    .dec           (dec)
  );

  exec_unit i_exec_unit (
    .clk       (clk),
    .reset     (reset),
    .dec_valid (dec_valid),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .ex_valid  (ex_valid),
    .ex_result (ex_result)
  );

  register_file i_register_file (
    .clk       (clk),
    .reset     (reset),
    .stackptr  (stackptr),
    .rs1       (dec.rs1),
    .rs2       (dec.rs2),
    .ex_valid  (ex_valid),
    .ex_result (ex_result),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

endmodule
